// ==== verification/tlb_stim.txt ====
# op vpn ppn perm exp_hit exp_ppn, all hex; op L lookup, F fill, X flush
# perm is the fill permission, or the expected permission on a lookup
L 12345 00000 0 0 00000
L 00000 00000 0 0 00000
F 12345 ABCDE 3 0 00000
L 12345 00000 3 1 ABCDE
L 99995 00000 0 0 00000
F 99995 11111 1 0 00000
L 99995 00000 1 1 11111
L 12345 00000 3 1 ABCDE
F 55555 22222 2 0 00000
L 12345 00000 0 0 00000
L 55555 00000 2 1 22222
L 99995 00000 1 1 11111
F 0A00C 33333 0 0 00000
L 0A00C 00000 0 1 33333
F 7777C 44444 3 0 00000
L 7777C 00000 3 1 44444
F 3210C 55555 1 0 00000
L 0A00C 00000 0 0 00000
L 7777C 00000 3 1 44444
L 3210C 00000 1 1 55555
X 00000 00000 0 0 00000
L 55555 00000 0 0 00000
L 99995 00000 0 0 00000
L 3210C 00000 0 0 00000
F 12345 66666 2 0 00000
L 12345 00000 2 1 66666
F FFFFF FFFFF 3 0 00000
L FFFFF 00000 3 1 FFFFF

// ==== build.f ====
+incdir+include
hw/tlb_pkg.sv
hw/tlb_ram.sv
hw/tlb_inv_way.sv
hw/tlb_hit_merge.sv
hw/tlb_ctrl.sv
hw/tlb_top.sv
verification/tb_tlb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the translation buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=tb_tlb_sim

# Compile
verilator --binary --timing -f build.f --top-module tb_tlb -Mdir obj_dir -o "$EXE"
if [ $? -ne 0 ]; then
        echo "Verilator compile failed"
        exit 1
fi

# Run
./obj_dir/"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

# Verdict comes from the log
if grep -qxF "All tests passed!" "$LOG"; then
        exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== verification/tb_tlb.sv ====
// Translation buffer testbench

`timescale 1ns/10ps

`include "tlb_defines.svh"

module tb_tlb;

        import tlb_pkg::*;

        // Edges from the sampling edge to ack
        localparam int LKP_LAT    = 4;
        localparam int SHORT_LAT  = 1;
        localparam int WAIT_LIMIT = 50;

        localparam string STIM_FILE = "verification/tlb_stim.txt";

        logic                   i_clk;
        logic                   i_arst_n;
        logic                   i_lkp_req;
        logic [`TLB_VPN_W-1:0]  i_lkp_vpn;
        logic                   o_lkp_ack;
        logic                   o_lkp_hit;
        tlb_ppn_t               o_lkp_ppn;
        logic [`TLB_PERM_W-1:0] o_lkp_perm;
        logic                   i_fill_req;
        logic [`TLB_VPN_W-1:0]  i_fill_vpn;
        tlb_ppn_t               i_fill_ppn;
        logic [`TLB_PERM_W-1:0] i_fill_perm;
        logic                   o_fill_ack;
        logic                   i_flush_req;
        logic                   o_flush_ack;

        // Error bookkeeping
        int checks;
        int value_errs;
        int timeouts;
        int other_errs;

        tlb_top tlb_top_inst (
                .i_clk       (i_clk),
                .i_arst_n    (i_arst_n),
                .i_lkp_req   (i_lkp_req),
                .i_lkp_vpn   (i_lkp_vpn),
                .o_lkp_ack   (o_lkp_ack),
                .o_lkp_hit   (o_lkp_hit),
                .o_lkp_ppn   (o_lkp_ppn),
                .o_lkp_perm  (o_lkp_perm),
                .i_fill_req  (i_fill_req),
                .i_fill_vpn  (i_fill_vpn),
                .i_fill_ppn  (i_fill_ppn),
                .i_fill_perm (i_fill_perm),
                .o_fill_ack  (o_fill_ack),
                .i_flush_req (i_flush_req),
                .o_flush_ack (o_flush_ack)
        );

        // 40 ns clock
        initial
        begin
                i_clk = 1'b0;
                forever #20 i_clk = ~i_clk;
        end

        // ------------------------------
        // Helpers
        // ------------------------------

        task automatic check_value(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                checks++;
                if (exp !== act)
                begin
                        $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
                        value_errs++;
                end
        endtask

        // Ack belonging to an operation code
        function automatic logic ack_of(input logic [7:0] op);
                case (op)
                        "F":     return o_fill_ack;
                        "X":     return o_flush_ack;
                        default: return o_lkp_ack;
                endcase
        endfunction

        // Ack plus every lookup result packed for the hold compare
        function automatic logic [31:0] result_word(input logic [7:0] op);
                return {8'b0, ack_of(op), o_lkp_hit, o_lkp_perm, o_lkp_ppn};
        endfunction

        task automatic set_req(input logic [7:0] op, input logic level);
                case (op)
                        "F":     i_fill_req  = level;
                        "X":     i_flush_req = level;
                        default: i_lkp_req   = level;
                endcase
        endtask

        // Polls 2 ns after each edge when ack has settled
        task automatic wait_for_ack(input logic [7:0] op, input logic level,
                                    input string name, output int cycles, output logic ok);
                cycles = 0;
                ok     = 1'b0;
                while (!ok && (cycles < WAIT_LIMIT))
                begin
                        @(posedge i_clk);
                        #2;
                        cycles++;
                        ok = (ack_of(op) == level);
                end
                if (!ok)
                begin
                        $display("Timeout in %s: ack did not go to %0d within %0d cycles",
                                 name, level, WAIT_LIMIT);
                        timeouts++;
                end
        endtask

        // Under back-pressure ack and results must not move while req stays high
        task automatic hold_and_release(input logic [7:0] op, input string name, input int hold);
                logic [31:0] snap;
                int          cycles;
                logic        ok;
                snap = result_word(op);
                for (int i = 0; i < hold; i++)
                begin
                        @(posedge i_clk);
                        #2;
                        check_value($sformatf("%s held %0d", name, i + 1), snap, result_word(op));
                end
                set_req(op, 1'b0);
                wait_for_ack(op, 1'b0, name, cycles, ok);
        endtask

        task automatic run_op(input logic [7:0] op, input string name, input logic [31:0] vpn,
                              input logic [31:0] ppn, input logic [31:0] perm,
                              input logic [31:0] exp_hit, input logic [31:0] exp_ppn,
                              input int hold);
                int   cycles;
                logic ok;
                int   lat;
                lat = (op == "L") ? LKP_LAT : SHORT_LAT;
                // Data settles with req and stays for the whole handshake
                i_lkp_vpn   = vpn[`TLB_VPN_W-1:0];
                i_fill_vpn  = vpn[`TLB_VPN_W-1:0];
                i_fill_ppn  = ppn[`TLB_PPN_W-1:0];
                i_fill_perm = perm[`TLB_PERM_W-1:0];
                set_req(op, 1'b1);
                wait_for_ack(op, 1'b1, name, cycles, ok);
                // First polled edge is the sampling edge
                if (ok)
                        check_value($sformatf("%s latency", name), lat, cycles - 1);
                if (ok && (op == "L"))
                begin
                        check_value($sformatf("%s hit", name), exp_hit, 32'(o_lkp_hit));
                        check_value($sformatf("%s ppn", name), exp_ppn, 32'(o_lkp_ppn));
                        // Perm column is the expected permission on a lookup
                        check_value($sformatf("%s perm", name), perm, 32'(o_lkp_perm));
                end
                hold_and_release(op, name, hold);
        endtask

        // ------------------------------
        // Main sequence
        // ------------------------------

        initial
        begin
                int          fd;
                int          n;
                int          fields;
                int          lnum;
                string       line;
                logic [7:0]  op_c;
                logic [31:0] vpn_v;
                logic [31:0] ppn_v;
                logic [31:0] perm_v;
                logic [31:0] hit_v;
                logic [31:0] exp_ppn_v;

                i_arst_n    = 1'b0;
                i_lkp_req   = 1'b0;
                i_lkp_vpn   = '0;
                i_fill_req  = 1'b0;
                i_fill_vpn  = '0;
                i_fill_ppn  = '0;
                i_fill_perm = '0;
                i_flush_req = 1'b0;
                checks      = 0;
                value_errs  = 0;
                timeouts    = 0;
                other_errs  = 0;
                lnum        = 0;

                fd = $fopen(STIM_FILE, "r");
                if (fd == 0)
                begin
                        $display("Could not open stimulus file %s", STIM_FILE);
                        other_errs++;
                end

                // Reset for 16 cycles
                repeat (16) @(posedge i_clk);
                #2;
                i_arst_n = 1'b1;
                @(posedge i_clk);
                #2;

                if (fd != 0)
                begin
                        while (!$feof(fd))
                        begin
                                line = "";
                                n = $fgets(line, fd);
                                lnum++;
                                // Skip blank and comment lines
                                if ((n > 0) && (line.len() > 1) && (line[0] != "#"))
                                begin
                                        fields = $sscanf(line, "%s %h %h %h %h %h", op_c, vpn_v,
                                                         ppn_v, perm_v, hit_v, exp_ppn_v);
                                        if (fields != 6)
                                        begin
                                                $display("Stimulus line %0d is malformed", lnum);
                                                other_errs++;
                                        end
                                        else if ((op_c != "L") && (op_c != "F") && (op_c != "X"))
                                        begin
                                                $display("Unknown operation on line %0d", lnum);
                                                other_errs++;
                                        end
                                        else
                                                // Hold length cycles through 0..3
                                                run_op(op_c, $sformatf("line %0d %s", lnum, op_c),
                                                       vpn_v, ppn_v, perm_v, hit_v, exp_ppn_v,
                                                       lnum % 4);
                                end
                        end
                        $fclose(fd);
                end

                $display("Checks %0d, value errors %0d, timeouts %0d, other errors %0d",
                         checks, value_errs, timeouts, other_errs);
                if ((value_errs + timeouts + other_errs) == 0)
                        $display("All tests passed!");
                else
                        $display("Test failures found");
                $finish;
        end

endmodule

// ==== hw/tlb_top.sv ====
// Two-way translation buffer top

`timescale 1ns/10ps

`include "tlb_defines.svh"

module tlb_top (
        input  logic                   i_clk,
        input  logic                   i_arst_n,
        // Lookup
        input  logic                   i_lkp_req,
        input  logic [`TLB_VPN_W-1:0]  i_lkp_vpn,
        output logic                   o_lkp_ack,
        output logic                   o_lkp_hit,
        output tlb_pkg::tlb_ppn_t      o_lkp_ppn,
        output logic [`TLB_PERM_W-1:0] o_lkp_perm,
        // Fill
        input  logic                   i_fill_req,
        input  logic [`TLB_VPN_W-1:0]  i_fill_vpn,
        input  tlb_pkg::tlb_ppn_t      i_fill_ppn,
        input  logic [`TLB_PERM_W-1:0] i_fill_perm,
        output logic                   o_fill_ack,
        // Flush
        input  logic                   i_flush_req,
        output logic                   o_flush_ack
);

        import tlb_pkg::*;

        // Controller to ways
        tlb_idx_t   rd_idx;
        tlb_idx_t   wr_idx;
        tlb_entry_t wr_entry;
        logic       we0;
        logic       we1;
        logic       flush;

        // Ways to merger
        tlb_entry_t way0_entry;
        tlb_entry_t way1_entry;
        logic       way0_valid;
        logic       way1_valid;

        // Merger back to controller
        tlb_tag_t               lkp_tag;
        logic                   mrg_hit;
        tlb_ppn_t               mrg_ppn;
        logic [`TLB_PERM_W-1:0] mrg_perm;

        tlb_ctrl ctrl_inst (
                .i_clk       (i_clk),
                .i_arst_n    (i_arst_n),
                .i_lkp_req   (i_lkp_req),
                .i_lkp_vpn   (i_lkp_vpn),
                .o_lkp_ack   (o_lkp_ack),
                .o_lkp_hit   (o_lkp_hit),
                .o_lkp_ppn   (o_lkp_ppn),
                .o_lkp_perm  (o_lkp_perm),
                .i_fill_req  (i_fill_req),
                .i_fill_vpn  (i_fill_vpn),
                .i_fill_ppn  (i_fill_ppn),
                .i_fill_perm (i_fill_perm),
                .o_fill_ack  (o_fill_ack),
                .i_flush_req (i_flush_req),
                .o_flush_ack (o_flush_ack),
                .o_rd_idx    (rd_idx),
                .o_tag       (lkp_tag),
                .o_we0       (we0),
                .o_we1       (we1),
                .o_wr_idx    (wr_idx),
                .o_wr_entry  (wr_entry),
                .o_flush     (flush),
                .i_hit       (mrg_hit),
                .i_ppn       (mrg_ppn),
                .i_perm      (mrg_perm)
        );

        // ------------------------------
        // Ways
        // ------------------------------

        tlb_inv_way way0_inst (
                .i_clk    (i_clk),
                .i_arst_n (i_arst_n),
                .i_we     (we0),
                .i_flush  (flush),
                .i_waddr  (wr_idx),
                .i_raddr  (rd_idx),
                .i_wdata  (wr_entry),
                .o_rdata  (way0_entry),
                .o_rvalid (way0_valid)
        );

        tlb_inv_way way1_inst (
                .i_clk    (i_clk),
                .i_arst_n (i_arst_n),
                .i_we     (we1),
                .i_flush  (flush),
                .i_waddr  (wr_idx),
                .i_raddr  (rd_idx),
                .i_wdata  (wr_entry),
                .o_rdata  (way1_entry),
                .o_rvalid (way1_valid)
        );

        // Winning way number is not needed outside
        tlb_hit_merge merge_inst (
                .i_clk        (i_clk),
                .i_arst_n     (i_arst_n),
                .i_tag        (lkp_tag),
                .i_way0_entry (way0_entry),
                .i_way1_entry (way1_entry),
                .i_way0_valid (way0_valid),
                .i_way1_valid (way1_valid),
                .o_hit        (mrg_hit),
                .o_hit_way    (),
                .o_ppn        (mrg_ppn),
                .o_perm       (mrg_perm)
        );

endmodule

// ==== hw/tlb_ctrl.sv ====
// Translation buffer handshake controller

`timescale 1ns/10ps

`include "tlb_defines.svh"

module tlb_ctrl (
        input  logic                   i_clk,
        input  logic                   i_arst_n,
        // Lookup
        input  logic                   i_lkp_req,
        input  logic [`TLB_VPN_W-1:0]  i_lkp_vpn,
        output logic                   o_lkp_ack,
        output logic                   o_lkp_hit,
        output tlb_pkg::tlb_ppn_t      o_lkp_ppn,
        output logic [`TLB_PERM_W-1:0] o_lkp_perm,
        // Fill
        input  logic                   i_fill_req,
        input  logic [`TLB_VPN_W-1:0]  i_fill_vpn,
        input  tlb_pkg::tlb_ppn_t      i_fill_ppn,
        input  logic [`TLB_PERM_W-1:0] i_fill_perm,
        output logic                   o_fill_ack,
        // Flush
        input  logic                   i_flush_req,
        output logic                   o_flush_ack,
        // Way side
        output tlb_pkg::tlb_idx_t      o_rd_idx,
        output tlb_pkg::tlb_tag_t      o_tag,
        output logic                   o_we0,
        output logic                   o_we1,
        output tlb_pkg::tlb_idx_t      o_wr_idx,
        output tlb_pkg::tlb_entry_t    o_wr_entry,
        output logic                   o_flush,
        // Merger result
        input  logic                   i_hit,
        input  tlb_pkg::tlb_ppn_t      i_ppn,
        input  logic [`TLB_PERM_W-1:0] i_perm
);

        import tlb_pkg::*;

        typedef enum logic [1:0] {S_IDLE, S_WAIT, S_HOLD, S_RELEASE} state_t;

        state_t   state;
        tlb_req_t kind;
        logic [1:0] cnt;
        // Global round-robin victim shared by every set
        logic     victim;
        logic     done;
        logic     req_cur;

        // Lookup waits three cycles for the merger while fill and flush need none
        always_comb
        begin
                done = (kind != REQ_LKP) || (cnt == 2'd3);
                case (kind)
                        REQ_FILL:  req_cur = i_fill_req;
                        REQ_FLUSH: req_cur = i_flush_req;
                        default:   req_cur = i_lkp_req;
                endcase
        end

        // ------------------------------
        // Handshake FSM
        // ------------------------------

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        state       <= S_IDLE;
                        kind        <= REQ_LKP;
                        cnt         <= 2'd0;
                        victim      <= 1'b0;
                        o_we0       <= 1'b0;
                        o_we1       <= 1'b0;
                        o_flush     <= 1'b0;
                        o_lkp_ack   <= 1'b0;
                        o_fill_ack  <= 1'b0;
                        o_flush_ack <= 1'b0;
                        o_lkp_hit   <= 1'b0;
                end
                else
                begin
                        // Write and flush strobes are single pulses
                        o_we0   <= 1'b0;
                        o_we1   <= 1'b0;
                        o_flush <= 1'b0;
                        case (state)
                                S_IDLE:
                                begin
                                        cnt <= 2'd0;
                                        // Flush over fill over lookup
                                        if (i_flush_req)
                                        begin
                                                kind    <= REQ_FLUSH;
                                                o_flush <= 1'b1;
                                                state   <= S_WAIT;
                                        end
                                        else if (i_fill_req)
                                        begin
                                                kind   <= REQ_FILL;
                                                o_we0  <= !victim;
                                                o_we1  <= victim;
                                                victim <= !victim;
                                                state  <= S_WAIT;
                                        end
                                        else if (i_lkp_req)
                                        begin
                                                kind  <= REQ_LKP;
                                                state <= S_WAIT;
                                        end
                                end
                                S_WAIT:
                                begin
                                        if (done)
                                        begin
                                                o_lkp_ack   <= (kind == REQ_LKP);
                                                o_fill_ack  <= (kind == REQ_FILL);
                                                o_flush_ack <= (kind == REQ_FLUSH);
                                                if (kind == REQ_LKP)
                                                        o_lkp_hit <= i_hit;
                                                state <= S_HOLD;
                                        end
                                        else
                                                cnt <= cnt + 2'd1;
                                end
                                // Ack and results stay put while req is held
                                S_HOLD:
                                begin
                                        if (!req_cur)
                                                state <= S_RELEASE;
                                end
                                default:
                                begin
                                        o_lkp_ack   <= 1'b0;
                                        o_fill_ack  <= 1'b0;
                                        o_flush_ack <= 1'b0;
                                        state       <= S_IDLE;
                                end
                        endcase
                end
        end

        // Request data is captured in idle and the lookup result with ack
        always_ff @(posedge i_clk)
        begin
                if (state == S_IDLE)
                begin
                        o_rd_idx   <= i_lkp_vpn[TLB_IDX_W-1:0];
                        o_tag      <= i_lkp_vpn[`TLB_VPN_W-1:TLB_IDX_W];
                        o_wr_idx   <= i_fill_vpn[TLB_IDX_W-1:0];
                        o_wr_entry <= '{tag:  i_fill_vpn[`TLB_VPN_W-1:TLB_IDX_W],
                                        ppn:  i_fill_ppn,
                                        perm: i_fill_perm};
                end
                if ((state == S_WAIT) && done && (kind == REQ_LKP))
                begin
                        o_lkp_ppn  <= i_ppn;
                        o_lkp_perm <= i_perm;
                end
        end

endmodule

// ==== hw/tlb_hit_merge.sv ====
// Two-way hit merger

`timescale 1ns/10ps

`include "tlb_defines.svh"

module tlb_hit_merge (
        input  logic                   i_clk,
        input  logic                   i_arst_n,
        input  tlb_pkg::tlb_tag_t      i_tag,
        input  tlb_pkg::tlb_entry_t    i_way0_entry,
        input  tlb_pkg::tlb_entry_t    i_way1_entry,
        input  logic                   i_way0_valid,
        input  logic                   i_way1_valid,
        output logic                   o_hit,
        output logic                   o_hit_way,
        output tlb_pkg::tlb_ppn_t      o_ppn,
        output logic [`TLB_PERM_W-1:0] o_perm
);

        import tlb_pkg::*;

        // Two-deep tag pipeline to match the way read latency
        tlb_tag_t tag_d1;
        tlb_tag_t tag_d2;

        logic hit0;
        logic hit1;

        always_ff @(posedge i_clk)
        begin
                tag_d1 <= i_tag;
                tag_d2 <= tag_d1;
        end

        // Per-way compare
        always_comb
        begin
                hit0 = i_way0_valid && (i_way0_entry.tag == tag_d2);
                hit1 = i_way1_valid && (i_way1_entry.tag == tag_d2);
        end

        // Way 0 has priority and the result is zero on a miss
        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        o_hit     <= 1'b0;
                        o_hit_way <= 1'b0;
                        o_ppn     <= '0;
                        o_perm    <= '0;
                end
                else
                begin
                        o_hit     <= hit0 | hit1;
                        o_hit_way <= !hit0 && hit1;
                        if (hit0)
                        begin
                                o_ppn  <= i_way0_entry.ppn;
                                o_perm <= i_way0_entry.perm;
                        end
                        else if (hit1)
                        begin
                                o_ppn  <= i_way1_entry.ppn;
                                o_perm <= i_way1_entry.perm;
                        end
                        else
                        begin
                                o_ppn  <= '0;
                                o_perm <= '0;
                        end
                end
        end

endmodule

// ==== hw/tlb_inv_way.sv ====
// One way with single-cycle clear

`timescale 1ns/10ps

`include "tlb_defines.svh"

module tlb_inv_way (
        input  logic                i_clk,
        input  logic                i_arst_n,
        input  logic                i_we,
        input  logic                i_flush,
        input  tlb_pkg::tlb_idx_t   i_waddr,
        input  tlb_pkg::tlb_idx_t   i_raddr,
        input  tlb_pkg::tlb_entry_t i_wdata,
        output tlb_pkg::tlb_entry_t o_rdata,
        output logic                o_rvalid
);

        import tlb_pkg::*;

        // One valid bit per set kept out of the RAM so it clears at once
        logic [`TLB_SETS-1:0] valid_q;

        // Stage 1 state
        logic     rvalid_s1;
        logic     fwd_s1;
        logic     valid_s1;
        tlb_idx_t raddr_s1;

        // Entry storage
        tlb_ram ram_inst (
                .i_clk   (i_clk),
                .i_we    (i_we),
                .i_waddr (i_waddr),
                .i_raddr (i_raddr),
                .i_wdata (i_wdata),
                .o_rdata (o_rdata)
        );

        // Flush beats a write in the same cycle
        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                        valid_q <= '0;
                else if (i_flush)
                        valid_q <= '0;
                else if (i_we)
                        valid_q[i_waddr] <= 1'b1;
        end

        // ------------------------------
        // Stage 1
        // ------------------------------

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        rvalid_s1 <= 1'b0;
                        fwd_s1    <= 1'b0;
                end
                else if (i_flush)
                begin
                        rvalid_s1 <= 1'b0;
                        fwd_s1    <= 1'b0;
                end
                else
                begin
                        rvalid_s1 <= valid_q[i_raddr];
                        // Write lands on the index being read
                        fwd_s1    <= i_we && (i_waddr == i_raddr);
                end
        end

        // Index follows the read to compare against later writes
        always_ff @(posedge i_clk)
        begin
                raddr_s1 <= i_raddr;
        end

        always_comb
        begin
                valid_s1 = fwd_s1 | rvalid_s1;
        end

        // ------------------------------
        // Stage 2
        // ------------------------------

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                        o_rvalid <= 1'b0;
                else if (i_flush)
                        o_rvalid <= 1'b0;
                else
                        o_rvalid <= (i_we && (i_waddr == raddr_s1)) | valid_s1;
        end

endmodule

// ==== hw/tlb_ram.sv ====
// Entry RAM with two-stage read

`timescale 1ns/10ps

`include "tlb_defines.svh"

module tlb_ram (
        input  logic                i_clk,
        input  logic                i_we,
        input  tlb_pkg::tlb_idx_t   i_waddr,
        input  tlb_pkg::tlb_idx_t   i_raddr,
        input  tlb_pkg::tlb_entry_t i_wdata,
        output tlb_pkg::tlb_entry_t o_rdata
);

        import tlb_pkg::*;

        tlb_entry_t mem [`TLB_SETS];
        tlb_entry_t rdata_s1;
        tlb_idx_t   raddr_s1;

        // Write port
        always_ff @(posedge i_clk)
        begin
                if (i_we)
                        mem[i_waddr] <= i_wdata;
        end

        // Read path where new write data bypasses the array in either stage
        always_ff @(posedge i_clk)
        begin
                raddr_s1 <= i_raddr;

                if (i_we && (i_waddr == i_raddr))
                        rdata_s1 <= i_wdata;
                else
                        rdata_s1 <= mem[i_raddr];

                if (i_we && (i_waddr == raddr_s1))
                        o_rdata <= i_wdata;
                else
                        o_rdata <= rdata_s1;
        end

endmodule

// ==== hw/tlb_pkg.sv ====
// Translation buffer shared types

`include "tlb_defines.svh"

package tlb_pkg;

        // Set index comes from the low VPN bits
        localparam int TLB_IDX_W = $clog2(`TLB_SETS);

        // Tag is whatever is left of the VPN above the index
        localparam int TLB_TAG_W = `TLB_VPN_W - TLB_IDX_W;

        typedef logic [TLB_IDX_W-1:0]  tlb_idx_t;
        typedef logic [TLB_TAG_W-1:0]  tlb_tag_t;
        typedef logic [`TLB_PPN_W-1:0] tlb_ppn_t;

        // One stored translation of 38 bits
        typedef struct packed {
                tlb_tag_t               tag;
                tlb_ppn_t               ppn;
                logic [`TLB_PERM_W-1:0] perm;
        } tlb_entry_t;

        // Kind of request being served by the controller
        typedef enum logic [1:0] {
                REQ_LKP,
                REQ_FILL,
                REQ_FLUSH
        } tlb_req_t;

endpackage

// ==== include/tlb_defines.svh ====
// Translation buffer sizing macros

`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// ------------------------------
// Address and entry widths
// ------------------------------

// Virtual page number width
`define TLB_VPN_W 20

// Physical page number width
`define TLB_PPN_W 20

// Permission field width
`define TLB_PERM_W 2

// ------------------------------
// Geometry
// ------------------------------

// Sets per way as a power of two
`define TLB_SETS 16

`endif
